/* verilog/dma_pkg.sv */
// --------------------------------------
// cache dma bridge definitions
// word and address widths, block geometry
// and the column channel states
// --------------------------------------
package dma_pkg;

  localparam int data_width_lp       = 32;
  localparam int block_words_lp      = 4;
  localparam int block_addr_width_lp = 8;  // 256 blocks
  localparam int word_addr_width_lp  = block_addr_width_lp + $clog2(block_words_lp);
  localparam int mem_words_lp        = 1 << word_addr_width_lp;

  typedef logic [data_width_lp-1:0]           word_t;
  typedef logic [block_addr_width_lp-1:0]     block_addr_t;
  typedef logic [word_addr_width_lp-1:0]      word_addr_t;
  typedef logic [$clog2(block_words_lp)-1:0]  word_idx_t;

  // offset of the final word in a block
  localparam word_idx_t last_word_idx_lp = word_idx_t'(block_words_lp - 1);

  typedef enum logic [2:0] {
    idle,
    evict_collect,  // gathering evict words from the cache
    wait_grant,
    write_words,
    read_words,
    done            // draining the last fill word
  } chan_state_e;

endpackage

/* verilog/dma_mem_if.sv */
// --------------------------------------
// channel to arbiter memory link
// one block owner issues word accesses
// --------------------------------------
`timescale 1ns/1ps

interface dma_mem_if;

  logic                req;
  logic                gnt;
  logic                we;
  dma_pkg::word_addr_t addr;
  dma_pkg::word_t      wdata;
  logic                word_v;   // one access this cycle
  dma_pkg::word_t      rdata;
  logic                rdata_v;  // one cycle after a read word_v
  logic                last;

  modport channel (
    output req, we, addr, wdata, word_v, last,
    input  gnt, rdata, rdata_v
  );

  modport arbiter (
    input  req, we, addr, wdata, word_v, last,
    output gnt, rdata, rdata_v
  );

endinterface

/* verilog/dma_channel.sv */
// --------------------------------------
// column dma channel
// accepts one fill or evict packet, then
// streams the block words over the
// memory link while it holds the grant
// --------------------------------------
`timescale 1ns/1ps

module dma_channel (
  input  logic                 core_clk,
  input  logic                 arst_n_i,
  // packet
  input  logic                 dma_pkt_v_i,
  input  logic                 dma_pkt_write_i,
  input  dma_pkg::block_addr_t dma_pkt_addr_i,
  output logic                 dma_pkt_yumi_o,
  // evict data
  input  logic                 evict_v_i,
  input  dma_pkg::word_t       evict_data_i,
  output logic                 evict_yumi_o,
  // fill data
  output logic                 fill_v_o,
  output dma_pkg::word_t       fill_data_o,
  input  logic                 fill_ready_i,
  // memory
  dma_mem_if.channel           mem
);

  dma_pkg::chan_state_e state_r;
  dma_pkg::word_idx_t   idx_r;
  logic                 yumi_r;
  logic                 pending_r;   // read in flight
  logic                 fill_v_r;
  dma_pkg::word_t       fill_data_r;
  logic                 pkt_write_r;
  dma_pkg::block_addr_t pkt_addr_r;
  dma_pkg::word_t       evict_buf_r [dma_pkg::block_words_lp];

  logic pkt_take;
  logic evict_take;
  logic rd_issue;
  logic last_idx;

  assign pkt_take   = (state_r == dma_pkg::idle) & dma_pkt_v_i;
  assign evict_take = (state_r == dma_pkg::evict_collect) & evict_v_i;
  assign rd_issue   = (state_r == dma_pkg::read_words) & ~pending_r & ~fill_v_r;
  assign last_idx   = (idx_r == dma_pkg::last_word_idx_lp);

  assign dma_pkt_yumi_o = yumi_r;
  assign evict_yumi_o   = evict_take;
  assign fill_v_o       = fill_v_r;
  assign fill_data_o    = fill_data_r;

  assign mem.req    = (state_r == dma_pkg::wait_grant)
                    | (state_r == dma_pkg::write_words)
                    | (state_r == dma_pkg::read_words);
  assign mem.we     = pkt_write_r;
  assign mem.addr   = {pkt_addr_r, idx_r};
  assign mem.wdata  = evict_buf_r[idx_r];
  assign mem.word_v = (state_r == dma_pkg::write_words) | rd_issue;
  assign mem.last   = mem.word_v & last_idx;

  always_ff @(posedge core_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r   <= dma_pkg::idle;
      idx_r     <= '0;
      yumi_r    <= 1'b0;
      pending_r <= 1'b0;
      fill_v_r  <= 1'b0;
    end else begin
      yumi_r <= pkt_take;  // single pulse, state leaves idle

      if (rd_issue) begin
        pending_r <= 1'b1;
      end else if (mem.rdata_v) begin
        pending_r <= 1'b0;
      end

      if (fill_v_r && fill_ready_i) fill_v_r <= 1'b0;
      if (mem.rdata_v)               fill_v_r <= 1'b1;

      case (state_r)
        dma_pkg::idle: begin
          idx_r <= '0;
          if (dma_pkt_v_i) begin
            state_r <= dma_pkt_write_i ? dma_pkg::evict_collect : dma_pkg::wait_grant;
          end
        end
        dma_pkg::evict_collect: begin
          if (evict_v_i) begin
            idx_r <= idx_r + 1'b1;  // wraps back to offset 0
            if (last_idx) state_r <= dma_pkg::wait_grant;
          end
        end
        dma_pkg::wait_grant: begin
          if (mem.gnt) begin
            state_r <= pkt_write_r ? dma_pkg::write_words : dma_pkg::read_words;
          end
        end
        dma_pkg::write_words: begin
          idx_r <= idx_r + 1'b1;
          if (last_idx) state_r <= dma_pkg::done;
        end
        dma_pkg::read_words: begin
          if (rd_issue) begin
            idx_r <= idx_r + 1'b1;
            if (last_idx) state_r <= dma_pkg::done;
          end
        end
        default: begin
          // wait for the final fill word to leave
          if (!pending_r && !fill_v_r) state_r <= dma_pkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (pkt_take) begin
      pkt_write_r <= dma_pkt_write_i;
      pkt_addr_r  <= dma_pkt_addr_i;
    end
    if (evict_take)  evict_buf_r[idx_r] <= evict_data_i;
    if (mem.rdata_v) fill_data_r        <= mem.rdata;
  end

  a_fill_hold: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    fill_v_o && !fill_ready_i |=> fill_v_o && $stable(fill_data_o))
    else $error("fill word changed or dropped before fill_ready");

  // arbiter must keep the grant for the whole block
  a_word_gnt: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    mem.word_v |-> mem.gnt)
    else $error("word access issued without grant");

endmodule

/* verilog/block_mem_arbiter.sv */
// --------------------------------------
// round-robin block arbiter
// grants one channel a whole block and
// serves it from the shared word memory
// --------------------------------------
`timescale 1ns/1ps

module block_mem_arbiter (
  input  logic        core_clk,
  input  logic        arst_n_i,
  dma_mem_if.arbiter  ch0,
  dma_mem_if.arbiter  ch1
);

  logic gnt0_r;
  logic gnt1_r;
  logic rr_r;        // set when ch1 goes first
  logic rdata_v0_r;
  logic rdata_v1_r;

  dma_pkg::word_t rdata_r;
  dma_pkg::word_t mem_r [dma_pkg::mem_words_lp];

  logic                busy;
  logic                done0;
  logic                done1;
  logic                sel_word_v;
  logic                sel_we;
  dma_pkg::word_addr_t sel_addr;
  dma_pkg::word_t      sel_wdata;

  assign busy  = gnt0_r | gnt1_r;
  assign done0 = gnt0_r & ch0.word_v & ch0.last;
  assign done1 = gnt1_r & ch1.word_v & ch1.last;

  // owner's access onto the array
  assign sel_word_v = (gnt0_r & ch0.word_v) | (gnt1_r & ch1.word_v);
  assign sel_we     = gnt1_r ? ch1.we    : ch0.we;
  assign sel_addr   = gnt1_r ? ch1.addr  : ch0.addr;
  assign sel_wdata  = gnt1_r ? ch1.wdata : ch0.wdata;

  always_ff @(posedge core_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt0_r <= 1'b0;
      gnt1_r <= 1'b0;
      rr_r   <= 1'b0;
    end else if (done0) begin
      gnt0_r <= 1'b0;
      rr_r   <= 1'b1;  // ch1 next in line
    end else if (done1) begin
      gnt1_r <= 1'b0;
      rr_r   <= 1'b0;
    end else if (!busy) begin
      if (ch0.req && (!ch1.req || !rr_r)) begin
        gnt0_r <= 1'b1;
      end else if (ch1.req) begin
        gnt1_r <= 1'b1;
      end
    end
  end

  // read returns only to the owner
  always_ff @(posedge core_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_v0_r <= 1'b0;
      rdata_v1_r <= 1'b0;
    end else begin
      rdata_v0_r <= gnt0_r & ch0.word_v & ~ch0.we;
      rdata_v1_r <= gnt1_r & ch1.word_v & ~ch1.we;
    end
  end

  always_ff @(posedge core_clk) begin
    if (sel_word_v && sel_we) begin
      mem_r[sel_addr] <= sel_wdata;
    end
    rdata_r <= mem_r[sel_addr];  // one cycle read
  end

  assign ch0.gnt     = gnt0_r;
  assign ch1.gnt     = gnt1_r;
  assign ch0.rdata   = rdata_r;
  assign ch1.rdata   = rdata_r;
  assign ch0.rdata_v = rdata_v0_r;
  assign ch1.rdata_v = rdata_v1_r;

  a_one_owner: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    !(gnt0_r && gnt1_r))
    else $error("both channels granted");

endmodule

/* verilog/cache_dma_bridge.sv */
// --------------------------------------
// cache to memory dma bridge
// two column channels sharing one
// backing memory by block arbitration
// --------------------------------------
`timescale 1ns/1ps

module cache_dma_bridge (
  input  logic                 core_clk,
  input  logic                 arst_n_i,
  // column 0
  input  logic                 c0_dma_pkt_v_i,
  input  logic                 c0_dma_pkt_write_i,
  input  dma_pkg::block_addr_t c0_dma_pkt_addr_i,
  output logic                 c0_dma_pkt_yumi_o,
  input  logic                 c0_evict_v_i,
  input  dma_pkg::word_t       c0_evict_data_i,
  output logic                 c0_evict_yumi_o,
  output logic                 c0_fill_v_o,
  output dma_pkg::word_t       c0_fill_data_o,
  input  logic                 c0_fill_ready_i,
  // column 1
  input  logic                 c1_dma_pkt_v_i,
  input  logic                 c1_dma_pkt_write_i,
  input  dma_pkg::block_addr_t c1_dma_pkt_addr_i,
  output logic                 c1_dma_pkt_yumi_o,
  input  logic                 c1_evict_v_i,
  input  dma_pkg::word_t       c1_evict_data_i,
  output logic                 c1_evict_yumi_o,
  output logic                 c1_fill_v_o,
  output dma_pkg::word_t       c1_fill_data_o,
  input  logic                 c1_fill_ready_i
);

  dma_mem_if mem0_if ();
  dma_mem_if mem1_if ();

  dma_channel u_chan0 (
    .core_clk        (core_clk),
    .arst_n_i        (arst_n_i),
    .dma_pkt_v_i     (c0_dma_pkt_v_i),
    .dma_pkt_write_i (c0_dma_pkt_write_i),
    .dma_pkt_addr_i  (c0_dma_pkt_addr_i),
    .dma_pkt_yumi_o  (c0_dma_pkt_yumi_o),
    .evict_v_i       (c0_evict_v_i),
    .evict_data_i    (c0_evict_data_i),
    .evict_yumi_o    (c0_evict_yumi_o),
    .fill_v_o        (c0_fill_v_o),
    .fill_data_o     (c0_fill_data_o),
    .fill_ready_i    (c0_fill_ready_i),
    .mem             (mem0_if.channel)
  );

  dma_channel u_chan1 (
    .core_clk        (core_clk),
    .arst_n_i        (arst_n_i),
    .dma_pkt_v_i     (c1_dma_pkt_v_i),
    .dma_pkt_write_i (c1_dma_pkt_write_i),
    .dma_pkt_addr_i  (c1_dma_pkt_addr_i),
    .dma_pkt_yumi_o  (c1_dma_pkt_yumi_o),
    .evict_v_i       (c1_evict_v_i),
    .evict_data_i    (c1_evict_data_i),
    .evict_yumi_o    (c1_evict_yumi_o),
    .fill_v_o        (c1_fill_v_o),
    .fill_data_o     (c1_fill_data_o),
    .fill_ready_i    (c1_fill_ready_i),
    .mem             (mem1_if.channel)
  );

  block_mem_arbiter u_arb (
    .core_clk (core_clk),
    .arst_n_i (arst_n_i),
    .ch0      (mem0_if.arbiter),
    .ch1      (mem1_if.arbiter)
  );

endmodule

/* bench/bridge_tb_tasks.svh */
// --------------------------------------
// bridge testbench cache-side drivers
// packet, evict and fill handshakes,
// each wait bounded by a timeout
// --------------------------------------
`ifndef BRIDGE_TB_TASKS_SVH
`define BRIDGE_TB_TASKS_SVH

task automatic send_packet(input bit col, input bit is_write,
                           input dma_pkg::block_addr_t addr);
  int wait_cnt;
  @(posedge core_clk);
  pkt_v[col]     <= 1'b1;
  pkt_write[col] <= is_write;
  pkt_addr[col]  <= addr;
  first_pkt_sent <= 1'b1;
  wait_cnt = 0;
  do begin
    @(posedge core_clk);
    wait_cnt++;
    if (wait_cnt > timeout_cycles_lp) begin
      wait_timeout($sformatf("column %0d packet was never accepted", col));
    end
  end while (!pkt_yumi[col]);
  pkt_v[col] <= 1'b0;  // yumi seen, drop the packet
endtask

task automatic write_block(input bit col, input dma_pkg::block_addr_t addr);
  dma_pkg::word_t blk [dma_pkg::block_words_lp];
  int taken;
  int wait_cnt;
  for (int i = 0; i < dma_pkg::block_words_lp; i++) begin
    blk[i] = $urandom;
    ref_mem[{addr, dma_pkg::word_idx_t'(i)}] = blk[i];
  end
  send_packet(col, 1'b1, addr);
  evict_v[col]    <= 1'b1;
  evict_data[col] <= blk[0];
  taken    = 0;
  wait_cnt = 0;
  while (taken < dma_pkg::block_words_lp) begin
    @(posedge core_clk);
    wait_cnt++;
    if (evict_yumi[col]) begin
      taken++;
      wait_cnt = 0;
      if (taken < dma_pkg::block_words_lp) evict_data[col] <= blk[taken];
    end
    if (wait_cnt > timeout_cycles_lp) begin
      wait_timeout($sformatf("column %0d evict word %0d was never taken", col, taken));
    end
  end
  evict_v[col] <= 1'b0;
endtask

// stall adds random fill_ready gaps
task automatic read_block(input bit col, input dma_pkg::block_addr_t addr, input bit stall);
  int got;
  int wait_cnt;
  rd_addr[col] <= addr;
  rd_idx[col]  <= '0;
  send_packet(col, 1'b0, addr);
  fill_ready[col] <= 1'b1;
  got      = 0;
  wait_cnt = 0;
  while (got < dma_pkg::block_words_lp) begin
    @(posedge core_clk);
    wait_cnt++;
    if (fill_v[col] && fill_ready[col]) begin
      got++;
      wait_cnt = 0;
      rd_idx[col] <= rd_idx[col] + 1'b1;
    end
    if (wait_cnt > timeout_cycles_lp) begin
      wait_timeout($sformatf("column %0d fill word %0d never arrived", col, got));
    end
    fill_ready[col] <= stall ? ($urandom_range(0, 2) != 0) : 1'b1;
  end
  fill_ready[col] <= 1'b0;
endtask

`endif

/* bench/bridge_tb.sv */
// --------------------------------------
// cache dma bridge testbench
// drives both columns with evicts and
// fills; assertions compare fill data
// with a block reference model
// --------------------------------------
`timescale 1ns/1ps

module bridge_tb;

  localparam int timeout_cycles_lp = 200;

  logic core_clk;
  logic arst_n_i;

  logic [1:0]           pkt_v;
  logic [1:0]           pkt_write;
  dma_pkg::block_addr_t pkt_addr [2];
  logic [1:0]           evict_v;
  dma_pkg::word_t       evict_data [2];
  logic [1:0]           fill_ready;

  wire [1:0]      pkt_yumi;
  wire [1:0]      evict_yumi;
  wire [1:0]      fill_v;
  dma_pkg::word_t c0_fill_data;
  dma_pkg::word_t c1_fill_data;

  dma_pkg::word_t       ref_mem [dma_pkg::mem_words_lp];  // written block contents
  dma_pkg::block_addr_t rd_addr [2];
  dma_pkg::word_idx_t   rd_idx [2];    // next expected fill offset
  dma_pkg::word_t       exp_fill [2];
  logic                 first_pkt_sent;
  int                   err_cnt;

  assign exp_fill[0] = ref_mem[{rd_addr[0], rd_idx[0]}];
  assign exp_fill[1] = ref_mem[{rd_addr[1], rd_idx[1]}];

  cache_dma_bridge DUT (
    .core_clk           (core_clk),
    .arst_n_i           (arst_n_i),
    .c0_dma_pkt_v_i     (pkt_v[0]),
    .c0_dma_pkt_write_i (pkt_write[0]),
    .c0_dma_pkt_addr_i  (pkt_addr[0]),
    .c0_dma_pkt_yumi_o  (pkt_yumi[0]),
    .c0_evict_v_i       (evict_v[0]),
    .c0_evict_data_i    (evict_data[0]),
    .c0_evict_yumi_o    (evict_yumi[0]),
    .c0_fill_v_o        (fill_v[0]),
    .c0_fill_data_o     (c0_fill_data),
    .c0_fill_ready_i    (fill_ready[0]),
    .c1_dma_pkt_v_i     (pkt_v[1]),
    .c1_dma_pkt_write_i (pkt_write[1]),
    .c1_dma_pkt_addr_i  (pkt_addr[1]),
    .c1_dma_pkt_yumi_o  (pkt_yumi[1]),
    .c1_evict_v_i       (evict_v[1]),
    .c1_evict_data_i    (evict_data[1]),
    .c1_evict_yumi_o    (evict_yumi[1]),
    .c1_fill_v_o        (fill_v[1]),
    .c1_fill_data_o     (c1_fill_data),
    .c1_fill_ready_i    (fill_ready[1])
  );

  initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;
  end

  task automatic stop_with_failure();
    err_cnt++;
    $display("Done: errors found");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
    $display("ERR %0t %s expected %h actual %h", $time, name, exp_val, act_val);
    stop_with_failure();
  endtask

  task automatic wait_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    stop_with_failure();
  endtask

  `include "bridge_tb_tasks.svh"

  // nothing handshakes before the first packet
  a_quiet: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    !first_pkt_sent |-> ({pkt_yumi, evict_yumi, fill_v} == '0))
    else value_mismatch("yumi and fill_v outputs", 32'd0,
                        32'($sampled({pkt_yumi, evict_yumi, fill_v})));

  a_c0_fill_data: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    fill_v[0] && fill_ready[0] |-> c0_fill_data == exp_fill[0])
    else value_mismatch("c0_fill_data_o", $sampled(exp_fill[0]), $sampled(c0_fill_data));

  a_c1_fill_data: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    fill_v[1] && fill_ready[1] |-> c1_fill_data == exp_fill[1])
    else value_mismatch("c1_fill_data_o", $sampled(exp_fill[1]), $sampled(c1_fill_data));

  a_c0_fill_hold: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    fill_v[0] && !fill_ready[0] |=> fill_v[0])
    else value_mismatch("c0_fill_v_o", 32'd1, 32'd0);

  a_c1_fill_hold: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    fill_v[1] && !fill_ready[1] |=> fill_v[1])
    else value_mismatch("c1_fill_v_o", 32'd1, 32'd0);

  initial begin
    dma_pkg::block_addr_t blk_a;
    bit                   col_a;
    void'($urandom(32'hd68b_1b33));
    err_cnt        = 0;
    arst_n_i       <= 1'b0;
    pkt_v          <= '0;
    pkt_write      <= '0;
    evict_v        <= '0;
    fill_ready     <= '0;
    first_pkt_sent <= 1'b0;
    for (int c = 0; c < 2; c++) begin
      pkt_addr[c]   <= '0;
      evict_data[c] <= '0;
      rd_addr[c]    <= '0;
      rd_idx[c]     <= '0;
    end
    repeat (2) @(posedge core_clk);
    arst_n_i <= 1'b1;
    repeat (3) @(posedge core_clk);  // idle window

    write_block(1'b0, 8'h12);
    read_block(1'b0, 8'h12, 1'b0);

    // column 1 read marks the write done before column 0 reads it
    write_block(1'b1, 8'h5a);
    read_block(1'b1, 8'h5a, 1'b0);
    read_block(1'b0, 8'h5a, 1'b0);

    for (int i = 0; i < 4; i++) begin
      blk_a = dma_pkg::block_addr_t'($urandom_range(0, 255));
      col_a = i[0];
      write_block(col_a, blk_a);
      read_block(col_a, blk_a, 1'b1);
      read_block(~col_a, blk_a, 1'b1);
    end

    // packets on both columns in the same cycle
    for (int i = 0; i < 3; i++) begin
      blk_a = dma_pkg::block_addr_t'($urandom_range(0, 255));
      fork
        write_block(1'b0, blk_a);
        write_block(1'b1, blk_a ^ 8'h80);
      join
      fork
        read_block(1'b0, blk_a, 1'b1);
        read_block(1'b1, blk_a ^ 8'h80, 1'b1);
      join
    end

    repeat (2) @(posedge core_clk);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+bench
verilog/dma_pkg.sv
verilog/dma_mem_if.sv
verilog/dma_channel.sv
verilog/block_mem_arbiter.sv
verilog/cache_dma_bridge.sv
bench/bridge_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := bridge_tb
FILELIST := all.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS_MSG := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)

run: compile
	./$(OBJDIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
